//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing
TOP      = tb_cas_top
FILELIST = src.f

SRCS = $(shell grep -v '^+' $(FILELIST)) tb/tb_cas_tasks.svh
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

//--- hdl/cas_download.sv
//==============================
// Cassette image downloader
// Picks cassette writes out of the host
// download stream, forwards them to the tape
// buffer one cycle later, tracks the tape
// length and raises the loaded flag.
//==============================

`timescale 1ns/1ns

module cas_download #(
   parameter int BUF_AW = 10
) (
   input  logic                clock_bus,
   input  logic                rst_n,
   input  cas_pkg::ioctl_req_t ioctl,
   output cas_pkg::buf_wr_t    buf_wr,
   output logic                cas_busy,
   output logic                cas_loaded,
   output cas_pkg::tape_len_t  tape_len
);

   logic                is_cas;
   logic                is_cas_d;
   logic                dl_start;
   logic                dl_end;
   logic                in_range;
   logic                accept;

   logic                wr_en;
   cas_pkg::tape_addr_t wr_addr;
   cas_pkg::tape_byte_t wr_data;

   //==============================
   // Download decode
   //==============================

   // Only the low index bits select the cassette slot
   assign is_cas = ioctl.download & (ioctl.index[5:0] == cas_pkg::CAS_INDEX);

   // Upper address bits must be clear to fit the buffer
   assign in_range = ((ioctl.addr >> BUF_AW) == '0);

   assign accept   = is_cas & ioctl.wr & in_range;
   assign dl_start = is_cas & ~is_cas_d;
   assign dl_end   = ~is_cas & is_cas_d;

   // Player rewinds for as long as this is high
   assign cas_busy = is_cas;

   //==============================
   // Control state
   //==============================

   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         is_cas_d   <= 1'b0;
         wr_en      <= 1'b0;
         cas_loaded <= 1'b0;
         tape_len   <= '0;
      end else begin
         is_cas_d <= is_cas;
         wr_en    <= accept;

         // Flag drops on a new image and rises once it has ended
         if (dl_start) begin
            cas_loaded <= 1'b0;
         end else if (dl_end) begin
            cas_loaded <= 1'b1;
         end

         // Length follows the last accepted address
         if (accept) begin
            tape_len <= {1'b0, ioctl.addr} + 1'b1;
         end else if (dl_start) begin
            tape_len <= '0;
         end
      end
   end

   //==============================
   // Write payload
   //==============================

   always_ff @(posedge clock_bus) begin
      if (accept) begin
         wr_addr <= ioctl.addr;
         wr_data <= ioctl.data;
      end
   end

   assign buf_wr = '{en: wr_en, addr: wr_addr, data: wr_data};

endmodule

//--- hdl/cas_pkg.sv
//==============================
// Shared types for the cassette path
// Widths, the cassette download index,
// the host and buffer write structs and the
// player state encoding. Modules refer to
// these by scoped name.
//==============================

package cas_pkg;

   //==============================
   // Widths and constants
   //==============================

   // Host download address width
   localparam int ADDR_W = 16;

   // Low six index bits that mark a cassette image
   localparam logic [5:0] CAS_INDEX = 6'd5;

   //==============================
   // Scalar types
   //==============================

   typedef logic [7:0]        tape_byte_t;
   typedef logic [ADDR_W-1:0] tape_addr_t;

   // One extra bit so a full buffer length fits
   typedef logic [ADDR_W:0]   tape_len_t;

   //==============================
   // Structs
   //==============================

   // Host download port, 42 bits
   typedef struct packed {
      logic        download;
      logic [15:0] index;
      logic        wr;
      tape_addr_t  addr;
      tape_byte_t  data;
   } ioctl_req_t;

   // One write into the tape buffer, 25 bits
   typedef struct packed {
      logic       en;
      tape_addr_t addr;
      tape_byte_t data;
   } buf_wr_t;

   // Tape player states
   typedef enum logic [1:0] {
      PL_IDLE  = 2'd0,
      PL_FETCH = 2'd1,
      PL_SHIFT = 2'd2,
      PL_DONE  = 2'd3
   } player_state_t;

endpackage

//--- hdl/cas_top.sv
//==============================
// Cassette emulation top level
// Host download feeds the downloader, which
// fills the tape buffer; the player streams
// the buffer out on cas_out. Buffer size and
// bit period are set here.
//==============================

`timescale 1ns/1ns

module cas_top #(
   parameter int BUF_AW  = 10,
   parameter int BIT_DIV = 8
) (
   input  logic                clock_bus,
   input  logic                rst_n,
   input  cas_pkg::ioctl_req_t ioctl,
   input  logic                motor,
   input  logic                rewind_req,
   output logic                cas_out,
   output logic                cas_loaded,
   output logic                tape_end
);

   cas_pkg::buf_wr_t    buf_wr;
   logic                cas_busy;
   cas_pkg::tape_len_t  tape_len;
   cas_pkg::tape_addr_t rd_addr;
   cas_pkg::tape_byte_t rd_data;

   //==============================
   // Producer
   //==============================

   cas_download #(
      .BUF_AW (BUF_AW)
   ) u_download (
      .clock_bus  (clock_bus),
      .rst_n      (rst_n),
      .ioctl      (ioctl),
      .buf_wr     (buf_wr),
      .cas_busy   (cas_busy),
      .cas_loaded (cas_loaded),
      .tape_len   (tape_len)
   );

   //==============================
   // Buffer
   //==============================

   tape_buffer #(
      .BUF_AW (BUF_AW)
   ) u_buffer (
      .clock_bus (clock_bus),
      .buf_wr    (buf_wr),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data)
   );

   //==============================
   // Consumer
   //==============================

   // Plays while loaded and the motor line is low
   tape_player #(
      .BIT_DIV (BIT_DIV)
   ) u_player (
      .clock_bus  (clock_bus),
      .rst_n      (rst_n),
      .motor      (motor),
      .rewind_req (rewind_req),
      .cas_busy   (cas_busy),
      .cas_loaded (cas_loaded),
      .tape_len   (tape_len),
      .rd_addr    (rd_addr),
      .rd_data    (rd_data),
      .cas_out    (cas_out),
      .tape_end   (tape_end)
   );

endmodule

//--- hdl/tape_buffer.sv
//==============================
// On-chip tape buffer
// Byte memory with one write port fed by the
// downloader and one registered read port
// used by the player. Read data follows the
// address by one cycle.
//==============================

`timescale 1ns/1ns

module tape_buffer #(
   parameter int BUF_AW = 10
) (
   input  logic                clock_bus,
   input  cas_pkg::buf_wr_t    buf_wr,
   input  cas_pkg::tape_addr_t rd_addr,
   output cas_pkg::tape_byte_t rd_data
);

   localparam int DEPTH = 1 << BUF_AW;

   cas_pkg::tape_byte_t mem [0:DEPTH-1];

   logic [BUF_AW-1:0]   wr_idx;
   logic [BUF_AW-1:0]   rd_idx;

   // Only the low address bits reach the array
   assign wr_idx = buf_wr.addr[BUF_AW-1:0];
   assign rd_idx = rd_addr[BUF_AW-1:0];

   //==============================
   // Write port
   //==============================

   always_ff @(posedge clock_bus) begin
      if (buf_wr.en) begin
         mem[wr_idx] <= buf_wr.data;
      end
   end

   //==============================
   // Read port
   //==============================

   // Registered read, old data on a same-address write
   always_ff @(posedge clock_bus) begin
      rd_data <= mem[rd_idx];
   end

endmodule

//--- hdl/tape_player.sv
//==============================
// Cassette tape player
// Reads the tape buffer and plays each byte
// MSB first on cas_out, one bit per BIT_DIV
// cycles. Pauses while play is low, rewinds on
// request or during a download.
//==============================

`timescale 1ns/1ns

module tape_player #(
   parameter int BIT_DIV = 8
) (
   input  logic                clock_bus,
   input  logic                rst_n,
   input  logic                motor,
   input  logic                rewind_req,
   input  logic                cas_busy,
   input  logic                cas_loaded,
   input  cas_pkg::tape_len_t  tape_len,
   output cas_pkg::tape_addr_t rd_addr,
   input  cas_pkg::tape_byte_t rd_data,
   output logic                cas_out,
   output logic                tape_end
);

   // Counter is also used for the two FETCH cycles, so at least one bit
   localparam int               DIV_W    = (BIT_DIV > 2) ? $clog2(BIT_DIV) : 1;
   localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(BIT_DIV - 1);

   cas_pkg::player_state_t state;
   cas_pkg::tape_len_t     pos;
   logic [DIV_W-1:0]       div_cnt;
   logic [2:0]             bit_idx;
   cas_pkg::tape_byte_t    shift_reg;
   cas_pkg::tape_byte_t    hold_reg;

   logic                   play;
   logic                   rewind;
   logic                   step;
   logic                   bit_end;
   logic                   byte_end;
   logic                   last_byte;
   logic                   fetch_wait;
   logic                   capture;
   logic                   load_byte;
   logic                   shift_bit;

   //==============================
   // Timeline control
   //==============================

   assign play   = cas_loaded & ~motor;
   assign rewind = rewind_req | cas_busy;
   assign step   = play & ~rewind;

   assign bit_end    = (div_cnt == DIV_LAST);
   assign byte_end   = bit_end & (bit_idx == 3'd7);
   // pos is one past the byte now on the wire
   assign last_byte  = (pos == tape_len);
   // First of the two cycles spent in FETCH
   assign fetch_wait = (div_cnt == '0);

   // Next byte is latched as the last bit starts
   assign capture = step &
      (((state == cas_pkg::PL_FETCH) & fetch_wait) |
       ((state == cas_pkg::PL_SHIFT) & bit_end & (bit_idx == 3'd6)));

   assign load_byte = step &
      (((state == cas_pkg::PL_FETCH) & ~fetch_wait) |
       ((state == cas_pkg::PL_SHIFT) & byte_end & ~last_byte));

   assign shift_bit = step & (state == cas_pkg::PL_SHIFT) & bit_end & ~byte_end;

   //==============================
   // FSM and counters
   //==============================

   always_ff @(posedge clock_bus or negedge rst_n) begin
      if (!rst_n) begin
         state   <= cas_pkg::PL_IDLE;
         pos     <= '0;
         div_cnt <= '0;
         bit_idx <= '0;
      end else if (rewind) begin
         state   <= cas_pkg::PL_IDLE;
         pos     <= '0;
         div_cnt <= '0;
         bit_idx <= '0;
      end else if (play) begin
         case (state)
            cas_pkg::PL_IDLE: begin
               if (tape_len == '0) begin
                  state <= cas_pkg::PL_DONE;
               end else begin
                  state <= cas_pkg::PL_FETCH;
               end
            end
            cas_pkg::PL_FETCH: begin
               if (fetch_wait) begin
                  div_cnt <= DIV_W'(1);
               end else begin
                  state   <= cas_pkg::PL_SHIFT;
                  div_cnt <= '0;
                  bit_idx <= '0;
                  pos     <= pos + 1'b1;
               end
            end
            cas_pkg::PL_SHIFT: begin
               if (!bit_end) begin
                  div_cnt <= div_cnt + 1'b1;
               end else begin
                  div_cnt <= '0;
                  // Wraps to bit 0 at the byte boundary
                  bit_idx <= bit_idx + 1'b1;
                  if (byte_end) begin
                     if (last_byte) begin
                        state <= cas_pkg::PL_DONE;
                     end else begin
                        pos <= pos + 1'b1;
                     end
                  end
               end
            end
            default: begin
               // PL_DONE holds until rewound
               state <= cas_pkg::PL_DONE;
            end
         endcase
      end
   end

   //==============================
   // Data path
   //==============================

   always_ff @(posedge clock_bus) begin
      if (capture) begin
         hold_reg <= rd_data;
      end
      if (load_byte) begin
         shift_reg <= hold_reg;
      end else if (shift_bit) begin
         shift_reg <= {shift_reg[6:0], 1'b0};
      end
   end

   assign rd_addr  = pos[cas_pkg::ADDR_W-1:0];
   // Low outside PL_SHIFT, held during a pause
   assign cas_out  = (state == cas_pkg::PL_SHIFT) & shift_reg[7];
   assign tape_end = (state == cas_pkg::PL_DONE);

endmodule

//--- src.f
hdl/cas_pkg.sv
hdl/cas_download.sv
hdl/tape_buffer.sv
hdl/tape_player.sv
hdl/cas_top.sv
+incdir+tb
tb/tb_cas_top.sv

//--- tb/tb_cas_tasks.svh
//==============================
// Tasks for the cassette testbench
// Compares, host and tape drivers, the bit
// stream sampler and the directed tests
//==============================

`ifndef TB_CAS_TASKS_SVH
`define TB_CAS_TASKS_SVH

//==============================
// Compares and reporting
//==============================

task automatic compare_byte(input string name, input cas_pkg::tape_byte_t got,
                            input cas_pkg::tape_byte_t exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
   end
endtask

task automatic compare_flag(input string name, input logic got, input logic exp);
   checks++;
   if (got !== exp) begin
      errors++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
   end
endtask

task automatic note_timeout(input string what);
   errors++;
   $display("timeout waiting for %s", what);
endtask

task automatic end_test(input string name, input int err0);
   tests++;
   if (errors == err0) begin
      $display("%s: ok", name);
   end else begin
      $display("%s: %0d errors", name, errors - err0);
   end
endtask

//==============================
// Drivers
//==============================

task automatic fill_random(input int n);
   int i;
   for (i = 0; i < n; i++) begin
      dl_data[i] = cas_pkg::tape_byte_t'($random(seed));
   end
endtask

// One write strobe per byte, with an idle cycle between
task automatic download_tape(input logic [15:0] index, input int n);
   int i;
   @(posedge clock_bus);
   ioctl.download <= 1'b1;
   ioctl.index    <= index;
   for (i = 0; i < n; i++) begin
      @(posedge clock_bus);
      ioctl.wr   <= 1'b1;
      ioctl.addr <= cas_pkg::tape_addr_t'(i);
      ioctl.data <= dl_data[i];
      @(posedge clock_bus);
      ioctl.wr <= 1'b0;
   end
   @(posedge clock_bus);
   ioctl.download <= 1'b0;
endtask

task automatic wait_loaded();
   int cycles;
   cycles = 0;
   @(negedge clock_bus);
   while (cas_loaded !== 1'b1 && cycles < LOAD_TIMEOUT) begin
      @(negedge clock_bus);
      cycles++;
   end
   if (cas_loaded !== 1'b1) begin
      note_timeout("cas_loaded");
   end
endtask

task automatic rewind_tape();
   @(posedge clock_bus);
   rewind_req <= 1'b1;
   @(posedge clock_bus);
   rewind_req <= 1'b0;
endtask

// Lowers motor and rebuilds bytes from the middle of each bit period.
// Only edges where motor and rewind_req are low advance the bit timeline.
task automatic play_stream(input int n_bits, input bit expect_end,
                           input int pause_at, input int pause_len);
   int                  c;
   int                  k;
   int                  cycles;
   int                  pause_left;
   int                  pause_state;
   logic                step_nxt;
   logic                last_out;
   cas_pkg::tape_byte_t cur;
   c           = -1;
   k           = 0;
   cycles      = 0;
   pause_left  = 0;
   pause_state = 0;
   last_out    = 1'b0;
   cur         = '0;
   @(posedge clock_bus);
   motor <= 1'b0;
   @(negedge clock_bus);
   step_nxt = ~motor & ~rewind_req;
   while (k < n_bits && cycles < STREAM_TIMEOUT) begin
      @(posedge clock_bus);
      cycles++;
      if (pause_state == 0 && pause_at >= 0 && c == pause_at) begin
         motor       <= 1'b1;
         pause_state = 1;
         pause_left  = pause_len;
      end else if (pause_state == 1) begin
         if (pause_left == 0) begin
            motor       <= 1'b0;
            pause_state = 2;
         end else begin
            pause_left--;
         end
      end
      @(negedge clock_bus);
      if (step_nxt) begin
         c++;
         last_out = cas_out;
         if (c == 2 + k * BIT_DIV + BIT_DIV / 2) begin
            cur = {cur[6:0], cas_out};
            compare_flag("tape_end", tape_end, 1'b0);
            k++;
            if (k % 8 == 0) begin
               compare_byte($sformatf("cas_out byte %0d", k / 8 - 1), cur,
                            exp_tape[k / 8 - 1]);
            end
         end
      end else if (c >= 0) begin
         // The line must not move while paused
         compare_flag("cas_out", cas_out, last_out);
         compare_flag("tape_end", tape_end, 1'b0);
      end
      step_nxt = ~motor & ~rewind_req;
   end
   if (k < n_bits) begin
      note_timeout("cas_out bits");
   end else if (expect_end) begin
      cycles = 0;
      while (tape_end !== 1'b1 && cycles < END_TIMEOUT) begin
         @(negedge clock_bus);
         cycles++;
      end
      if (tape_end !== 1'b1) begin
         note_timeout("tape_end");
      end else begin
         compare_flag("cas_out", cas_out, 1'b0);
      end
   end
   @(posedge clock_bus);
   motor <= 1'b1;
endtask

//==============================
// Directed tests
//==============================

task automatic check_reset();
   int err0;
   err0 = errors;
   @(negedge clock_bus);
   compare_flag("cas_out", cas_out, 1'b0);
   compare_flag("tape_end", tape_end, 1'b0);
   compare_flag("cas_loaded", cas_loaded, 1'b0);
   end_test("reset", err0);
endtask

task automatic load_and_play();
   int err0;
   int i;
   err0 = errors;
   fill_random(6);
   for (i = 0; i < 6; i++) begin
      exp_tape[i] = dl_data[i];
   end
   // Index 5 is the cassette slot
   download_tape(16'd5, 6);
   wait_loaded();
   play_stream(48, 1'b1, -1, 0);
   end_test("load and play", err0);
endtask

task automatic other_index_ignored();
   int err0;
   err0 = errors;
   fill_random(6);
   download_tape(16'd3, 6);
   repeat (4) begin
      @(negedge clock_bus);
      compare_flag("cas_loaded", cas_loaded, 1'b1);
   end
   rewind_tape();
   play_stream(48, 1'b1, -1, 0);
   end_test("other index ignored", err0);
endtask

task automatic motor_pause();
   int err0;
   err0 = errors;
   rewind_tape();
   // Pause lands inside bit 3 of byte 1
   play_stream(48, 1'b1, 2 + 11 * BIT_DIV + 1, 10);
   end_test("motor pause", err0);
endtask

task automatic rewind_and_overflow();
   int err0;
   int i;
   err0 = errors;
   rewind_tape();
   play_stream(20, 1'b0, -1, 0);
   rewind_tape();
   play_stream(48, 1'b1, -1, 0);
   // Addresses 64 and up fall outside a 64 byte buffer
   fill_random(70);
   for (i = 0; i < 64; i++) begin
      exp_tape[i] = dl_data[i];
   end
   download_tape(16'd5, 70);
   wait_loaded();
   play_stream(512, 1'b1, -1, 0);
   end_test("rewind and overflow", err0);
endtask

`endif

//--- tb/tb_cas_top.sv
//==============================
// Testbench for the cassette top level
// Clock, reset, the DUT and the directed
// test sequence; tasks are included below
//==============================

`timescale 1ns/1ns

module tb_cas_top;

   localparam int BUF_AW  = 6;
   localparam int BIT_DIV = 4;

   // Cycle limits for the wait loops
   localparam int LOAD_TIMEOUT   = 32;
   localparam int STREAM_TIMEOUT = 8000;
   localparam int END_TIMEOUT    = 4 * BIT_DIV;

   logic                clock_bus;
   logic                rst_n;
   cas_pkg::ioctl_req_t ioctl;
   logic                motor;
   logic                rewind_req;
   logic                cas_out;
   logic                cas_loaded;
   logic                tape_end;

   // Bytes sent by the host and bytes expected back from the tape
   cas_pkg::tape_byte_t dl_data  [0:127];
   cas_pkg::tape_byte_t exp_tape [0:127];

   integer seed;
   int     errors;
   int     checks;
   int     tests;

   cas_top #(
      .BUF_AW  (BUF_AW),
      .BIT_DIV (BIT_DIV)
   ) uut (
      .clock_bus  (clock_bus),
      .rst_n      (rst_n),
      .ioctl      (ioctl),
      .motor      (motor),
      .rewind_req (rewind_req),
      .cas_out    (cas_out),
      .cas_loaded (cas_loaded),
      .tape_end   (tape_end)
   );

   `include "tb_cas_tasks.svh"

   initial begin
      clock_bus = 1'b0;
      forever #10 clock_bus = ~clock_bus;
   end

   //==============================
   // Test sequence
   //==============================

   initial begin
      seed   = 32'hc79f_15fc;
      errors = 0;
      checks = 0;
      tests  = 0;
      // Motor line starts high so nothing plays before a test asks
      rst_n      <= 1'b0;
      ioctl      <= '0;
      motor      <= 1'b1;
      rewind_req <= 1'b0;
      repeat (4) @(posedge clock_bus);
      rst_n <= 1'b1;

      check_reset();
      load_and_play();
      other_index_ignored();
      motor_pause();
      rewind_and_overflow();

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule
